/* include/cmm_consts.svh */
// Self-configuration store constants
// Packet type, word flag positions, record offsets and reset values

`ifndef CMM_CONSTS_SVH
`define CMM_CONSTS_SVH

// ----------------------------------------
// Packet recognition
// ----------------------------------------
`define CFG_TYPE        16'h0C1F
`define SOP_BIT         17
`define EOP_BIT         16
// Source address must carry this bit for a config packet
`define SA_CFG_BIT      7

// ----------------------------------------
// Record offsets
// ----------------------------------------
`define OFS_CARD_ID     6'd0
`define OFS_CODE_VER    6'd3
`define OFS_CH_ENA      6'd4
`define OFS_RUN_CYCLE   6'd6
`define OFS_RX_PORT1    6'd8
`define OFS_RX_PORT2    6'd12
`define OFS_TX_PORT1    6'd24
`define OFS_TX_PORT2    6'd28

// Last word of the 31-word record
`define OFS_LAST        6'd30

// ----------------------------------------
// Reset values
// ----------------------------------------
`define ENABLE_SLOT_RST 32'h0000C000

`endif

/* src/cmm_types_pkg.sv */
// Self-configuration store data types
// Widths of stream words, record fields and packet addresses

`default_nettype none

package cmm_types_pkg;

    // Flags in 17..16, data in 15..0
    typedef logic [17:0] sdu_word_t;
    typedef logic [15:0] cfg_half_t;

    typedef logic [31:0] id_t;
    typedef logic [7:0]  port_t;
    typedef logic [15:0] version_t;

    // Packet header fields
    typedef logic [7:0]  addr_t;
    typedef logic [3:0]  slot_t;

    // Record offset, saturates at all ones
    typedef logic [5:0]  offset_t;

endpackage

`default_nettype wire

/* src/cmm_parse_pkg.sv */
// Packet parser state encoding

`default_nettype none

package cmm_parse_pkg;

    // Header word, then type word, then payload or discard
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_type    = 2'd1,
        st_payload = 2'd2,
        st_drop    = 2'd3
    } parse_state_t;

endpackage

`default_nettype wire

/* src/cfg_pkt_parser.sv */
// Configuration packet parser
// Checks header and type of each received packet and forwards
// the payload words of packets addressed to this card

`timescale 1ns/10ps
`default_nettype none
`include "cmm_consts.svh"

module cfg_pkt_parser
    import cmm_types_pkg::*;
    import cmm_parse_pkg::*;
(
    input  wire       clk_12_5m,
    input  wire       rst_12_5m,
    input  wire       ex_rxsdu_dval,
    input  wire sdu_word_t ex_rxsdu_data,
    input  wire slot_t     slot_num,
    output logic      ex_cfg_dval,
    output sdu_word_t ex_cfg_data
);

    parse_state_t state;
    addr_t        dst_addr;
    addr_t        src_addr;
    logic         word_sop;
    logic         word_eop;
    logic         cfg_match;
    logic         take_payload;

    assign word_sop = ex_rxsdu_dval & ex_rxsdu_data[`SOP_BIT];
    assign word_eop = ex_rxsdu_data[`EOP_BIT];

    // Evaluated while the type word is on the bus
    assign cfg_match = (dst_addr[3:0] == slot_num) && src_addr[`SA_CFG_BIT] &&
                       (ex_rxsdu_data[15:0] == `CFG_TYPE);

    assign take_payload = ex_rxsdu_dval && !ex_rxsdu_data[`SOP_BIT] && (state == st_payload);

    // ----------------------------------------
    // Packet FSM
    // ----------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            state <= st_idle;
        end else if (word_sop) begin
            // A new start word always wins, even mid-packet
            state <= st_type;
        end else if (ex_rxsdu_dval) begin
            case (state)
                st_type: begin
                    if (word_eop) begin
                        state <= st_idle;
                    end else if (cfg_match) begin
                        state <= st_payload;
                    end else begin
                        state <= st_drop;
                    end
                end
                st_payload, st_drop: begin
                    if (word_eop) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Header addresses
    always_ff @(posedge clk_12_5m) begin
        if (word_sop) begin
            dst_addr <= ex_rxsdu_data[15:8];
            src_addr <= ex_rxsdu_data[7:0];
        end
    end

    // ----------------------------------------
    // Payload output
    // ----------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            ex_cfg_dval <= 1'b0;
        end else begin
            ex_cfg_dval <= take_payload;
        end
    end

    always_ff @(posedge clk_12_5m) begin
        if (take_payload) begin
            ex_cfg_data <= ex_rxsdu_data;
        end
    end

endmodule

`default_nettype wire

/* src/cfg_write_ctrl.sv */
// Configuration write control
// Merges local and remote words into one stream, tracks the record
// offset and locks the record once its last word is written

`timescale 1ns/10ps
`default_nettype none
`include "cmm_consts.svh"

module cfg_write_ctrl
    import cmm_types_pkg::*;
(
    input  wire            clk_12_5m,
    input  wire            rst_12_5m,
    input  wire            wr_self_cfg_dval,
    input  wire sdu_word_t wr_self_cfg_data,
    input  wire            ex_cfg_dval,
    input  wire sdu_word_t ex_cfg_data,
    output logic           wr_dval,
    output offset_t        wr_offset,
    output cfg_half_t      wr_half,
    output logic           cfg_en
);

    offset_t ofs_cnt;
    logic    sel_local;
    logic    sel_any;

    // Local port has priority, a colliding remote word is dropped
    assign sel_local = wr_self_cfg_dval & ~cfg_en;
    assign sel_any   = (wr_self_cfg_dval | ex_cfg_dval) & ~cfg_en;

    // ----------------------------------------
    // Offset counter
    // ----------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            ofs_cnt <= '0;
        end else if (sel_any) begin
            if (ofs_cnt != '1) begin
                ofs_cnt <= ofs_cnt + 6'd1;
            end
        end else begin
            // Any idle cycle restarts the record
            ofs_cnt <= '0;
        end
    end

    // Sticky once the last offset has gone through
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            cfg_en <= 1'b0;
        end else if (sel_any && (ofs_cnt == `OFS_LAST)) begin
            cfg_en <= 1'b1;
        end
    end

    // ----------------------------------------
    // Write strobe and word
    // ----------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            wr_dval <= 1'b0;
        end else begin
            wr_dval <= sel_any;
        end
    end

    always_ff @(posedge clk_12_5m) begin
        if (sel_any) begin
            wr_offset <= ofs_cnt;
            wr_half   <= sel_local ? wr_self_cfg_data[15:0] : ex_cfg_data[15:0];
        end
    end

endmodule

`default_nettype wire

/* src/cfg_field_regs.sv */
// Configuration field registers
// Decodes the record offset of each written word into its field

`timescale 1ns/10ps
`default_nettype none
`include "cmm_consts.svh"

module cfg_field_regs
    import cmm_types_pkg::*;
(
    input  wire            clk_12_5m,
    input  wire            rst_12_5m,
    input  wire            wr_dval,
    input  wire offset_t   wr_offset,
    input  wire cfg_half_t wr_half,
    output id_t            card_id,
    output version_t       code_version,
    output id_t            enable_slot,
    output version_t       run_cycle,
    output id_t            src_id1,
    output port_t          src_port1,
    output id_t            src_id2,
    output port_t          src_port2,
    output id_t            dst_id1,
    output port_t          dst_port1,
    output id_t            dst_id2,
    output port_t          dst_port2
);

    // ----------------------------------------
    // Offset decode
    // ----------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            card_id      <= '0;
            code_version <= '0;
            enable_slot  <= `ENABLE_SLOT_RST;
            run_cycle    <= '0;
            src_id1      <= '0;
            src_port1    <= '0;
            src_id2      <= '0;
            src_port2    <= '0;
            dst_id1      <= '0;
            dst_port1    <= '0;
            dst_id2      <= '0;
            dst_port2    <= '0;
        end else if (wr_dval) begin
            // Two-word fields take the low half first
            case (wr_offset)
                `OFS_CARD_ID:            card_id[15:0]      <= wr_half;
                `OFS_CARD_ID + 6'd1:     card_id[31:16]     <= wr_half;
                `OFS_CODE_VER:           code_version       <= wr_half;
                `OFS_CH_ENA:             enable_slot[15:0]  <= wr_half;
                `OFS_CH_ENA + 6'd1:      enable_slot[31:16] <= wr_half;
                `OFS_RUN_CYCLE:          run_cycle          <= wr_half;

                // Receive side connections
                `OFS_RX_PORT1:           src_id1[15:0]      <= wr_half;
                `OFS_RX_PORT1 + 6'd1:    src_id1[31:16]     <= wr_half;
                `OFS_RX_PORT1 + 6'd2:    src_port1          <= wr_half[7:0];
                `OFS_RX_PORT2:           src_id2[15:0]      <= wr_half;
                `OFS_RX_PORT2 + 6'd1:    src_id2[31:16]     <= wr_half;
                `OFS_RX_PORT2 + 6'd2:    src_port2          <= wr_half[7:0];

                // Transmit side connections
                `OFS_TX_PORT1:           dst_id1[15:0]      <= wr_half;
                `OFS_TX_PORT1 + 6'd1:    dst_id1[31:16]     <= wr_half;
                `OFS_TX_PORT1 + 6'd2:    dst_port1          <= wr_half[7:0];
                `OFS_TX_PORT2:           dst_id2[15:0]      <= wr_half;
                `OFS_TX_PORT2 + 6'd1:    dst_id2[31:16]     <= wr_half;
                `OFS_TX_PORT2 + 6'd2:    dst_port2          <= wr_half[7:0];

                // Reserved offsets are skipped
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/self_cfg_mem.sv */
// Self-configuration store, top level
// Takes the card record from the local port or from config packets
// in the receive FIFO and holds it as configuration fields

`timescale 1ns/10ps
`default_nettype none

module self_cfg_mem
    import cmm_types_pkg::*;
(
    input  wire            clk_12_5m,
    input  wire            rst_12_5m,
    // Receive FIFO
    input  wire            ex_rxsdu_empty,
    output wire            rxsdu_ex_rdreq,
    input  wire            ex_rxsdu_dval,
    input  wire sdu_word_t ex_rxsdu_data,
    // Local write port
    input  wire            wr_self_cfg_dval,
    input  wire sdu_word_t wr_self_cfg_data,
    // Configuration outputs
    input  wire slot_t     slot_num,
    output wire            cfg_en,
    output wire id_t       card_id,
    output wire version_t  code_version,
    output wire id_t       enable_slot,
    output wire version_t  run_cycle,
    output wire id_t       src_id1,
    output wire port_t     src_port1,
    output wire id_t       src_id2,
    output wire port_t     src_port2,
    output wire id_t       dst_id1,
    output wire port_t     dst_port1,
    output wire id_t       dst_id2,
    output wire port_t     dst_port2
);

    wire            ex_cfg_dval;
    wire sdu_word_t ex_cfg_data;
    wire            wr_dval;
    wire offset_t   wr_offset;
    wire cfg_half_t wr_half;

    // Read whenever the FIFO holds data
    assign rxsdu_ex_rdreq = ~ex_rxsdu_empty;

    cfg_pkt_parser i_cfg_pkt_parser (
        .clk_12_5m     (clk_12_5m),
        .rst_12_5m     (rst_12_5m),
        .ex_rxsdu_dval (ex_rxsdu_dval),
        .ex_rxsdu_data (ex_rxsdu_data),
        .slot_num      (slot_num),
        .ex_cfg_dval   (ex_cfg_dval),
        .ex_cfg_data   (ex_cfg_data)
    );

    cfg_write_ctrl i_cfg_write_ctrl (
        .clk_12_5m        (clk_12_5m),
        .rst_12_5m        (rst_12_5m),
        .wr_self_cfg_dval (wr_self_cfg_dval),
        .wr_self_cfg_data (wr_self_cfg_data),
        .ex_cfg_dval      (ex_cfg_dval),
        .ex_cfg_data      (ex_cfg_data),
        .wr_dval          (wr_dval),
        .wr_offset        (wr_offset),
        .wr_half          (wr_half),
        .cfg_en           (cfg_en)
    );

    cfg_field_regs i_cfg_field_regs (
        .clk_12_5m    (clk_12_5m),
        .rst_12_5m    (rst_12_5m),
        .wr_dval      (wr_dval),
        .wr_offset    (wr_offset),
        .wr_half      (wr_half),
        .card_id      (card_id),
        .code_version (code_version),
        .enable_slot  (enable_slot),
        .run_cycle    (run_cycle),
        .src_id1      (src_id1),
        .src_port1    (src_port1),
        .src_id2      (src_id2),
        .src_port2    (src_port2),
        .dst_id1      (dst_id1),
        .dst_port1    (dst_port1),
        .dst_id2      (dst_id2),
        .dst_port2    (dst_port2)
    );

endmodule

`default_nettype wire

/* testbench/tb_self_cfg_mem.sv */
// Self-configuration store testbench
// Directed tests over the local port and the receive FIFO path

`timescale 1ns/10ps
`default_nettype none
`include "cmm_consts.svh"

module tb_self_cfg_mem
    import cmm_types_pkg::*;
();

    logic      clk_12_5m = 1'b0;
    logic      rst_12_5m;
    logic      ex_rxsdu_empty, ex_rxsdu_dval, wr_self_cfg_dval;
    sdu_word_t ex_rxsdu_data, wr_self_cfg_data;
    slot_t     slot_num;
    logic      rxsdu_ex_rdreq, cfg_en;
    id_t       card_id, enable_slot, src_id1, src_id2, dst_id1, dst_id2;
    version_t  code_version, run_cycle;
    port_t     src_port1, src_port2, dst_port1, dst_port2;

    cfg_half_t   stim [0:30];
    cfg_half_t   rec [0:30];
    logic [31:0] rng_state = 32'd51673;
    int          value_errs = 0;
    int          other_errs = 0;

    self_cfg_mem i_self_cfg_mem (.*);

    always #100 clk_12_5m = ~clk_12_5m;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_id(input string name, input id_t got, input id_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_version(input string name, input version_t got, input version_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_port(input string name, input port_t got, input port_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // Field layout by record offset, low half from the lower offset
    task automatic check_record();
        check_id("card_id", card_id, {rec[1], rec[0]});
        check_version("code_version", code_version, rec[3]);
        check_id("enable_slot", enable_slot, {rec[5], rec[4]});
        check_version("run_cycle", run_cycle, rec[6]);
        check_id("src_id1", src_id1, {rec[9], rec[8]});
        check_port("src_port1", src_port1, rec[10][7:0]);
        check_id("src_id2", src_id2, {rec[13], rec[12]});
        check_port("src_port2", src_port2, rec[14][7:0]);
        check_id("dst_id1", dst_id1, {rec[25], rec[24]});
        check_port("dst_port1", dst_port1, rec[26][7:0]);
        check_id("dst_id2", dst_id2, {rec[29], rec[28]});
        check_port("dst_port2", dst_port2, rec[30][7:0]);
    endtask

    task automatic check_reset_fields();
        check_bit("cfg_en", cfg_en, 1'b0);
        check_id("card_id", card_id, '0);
        check_version("code_version", code_version, '0);
        check_id("enable_slot", enable_slot, `ENABLE_SLOT_RST);
        check_version("run_cycle", run_cycle, '0);
        check_id("src_id1", src_id1, '0);
        check_port("src_port1", src_port1, '0);
        check_id("src_id2", src_id2, '0);
        check_port("src_port2", src_port2, '0);
        check_id("dst_id1", dst_id1, '0);
        check_port("dst_port1", dst_port1, '0);
        check_id("dst_id2", dst_id2, '0);
        check_port("dst_port2", dst_port2, '0);
    endtask

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic apply_reset();
        rst_12_5m        <= 1'b0;
        ex_rxsdu_empty   <= 1'b1;
        ex_rxsdu_dval    <= 1'b0;
        ex_rxsdu_data    <= '0;
        wr_self_cfg_dval <= 1'b0;
        wr_self_cfg_data <= '0;
        slot_num         <= 4'h5;
        repeat (8) @(posedge clk_12_5m);
        rst_12_5m <= 1'b1;
        @(posedge clk_12_5m);
    endtask

    task automatic fill_stim();
        for (int i = 0; i < 31; i++) begin
            rng_state = xorshift32(rng_state);
            stim[i]   = rng_state[15:0];
        end
    endtask

    task automatic send_local(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk_12_5m);
            wr_self_cfg_dval <= 1'b1;
            wr_self_cfg_data <= {2'b00, stim[i]};
        end
        @(posedge clk_12_5m);
        wr_self_cfg_dval <= 1'b0;
    endtask

    // Header, type word, then stim as payload with end flag on the last
    task automatic send_packet(input addr_t dst, input addr_t src, input cfg_half_t typ);
        @(posedge clk_12_5m);
        ex_rxsdu_empty <= 1'b0;
        ex_rxsdu_dval  <= 1'b1;
        ex_rxsdu_data  <= {2'b10, dst, src};
        @(posedge clk_12_5m);
        ex_rxsdu_data <= {2'b00, typ};
        for (int i = 0; i < 31; i++) begin
            @(posedge clk_12_5m);
            ex_rxsdu_data <= {1'b0, i == 30, stim[i]};
        end
        @(posedge clk_12_5m);
        ex_rxsdu_dval  <= 1'b0;
        ex_rxsdu_empty <= 1'b1;
    endtask

    task automatic wait_cfg_en(input int limit);
        int n;
        n = 0;
        while (!cfg_en && n < limit) begin
            @(negedge clk_12_5m);
            n++;
        end
        if (!cfg_en) begin
            other_errs++;
            $display("Timeout at %0t: cfg_en never rose", $time);
        end
        // Last field lands one cycle after cfg_en
        repeat (2) @(negedge clk_12_5m);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset_state();
        apply_reset();
        @(negedge clk_12_5m);
        check_reset_fields();
        check_bit("rxsdu_ex_rdreq", rxsdu_ex_rdreq, 1'b0);
        @(posedge clk_12_5m);
        ex_rxsdu_empty <= 1'b0;
        @(negedge clk_12_5m);
        check_bit("rxsdu_ex_rdreq", rxsdu_ex_rdreq, 1'b1);
    endtask

    task automatic test_local_record();
        apply_reset();
        fill_stim();
        rec = stim;
        send_local(31);
        wait_cfg_en(100);
        check_record();
    endtask

    // Runs straight after the local record, without reset
    task automatic test_lock();
        fill_stim();
        send_local(31);
        repeat (4) @(negedge clk_12_5m);
        check_bit("cfg_en", cfg_en, 1'b1);
        check_record();
    endtask

    task automatic test_remote_record();
        apply_reset();
        fill_stim();
        rec = stim;
        send_packet(8'hA5, 8'h81, `CFG_TYPE);
        wait_cfg_en(100);
        check_record();
    endtask

    task automatic test_rejected();
        apply_reset();
        fill_stim();
        send_packet(8'hA6, 8'h81, `CFG_TYPE);
        send_packet(8'hA5, 8'h01, `CFG_TYPE);
        send_packet(8'hA5, 8'h81, 16'h0C1E);
        for (int n = 0; n < 50; n++) begin
            @(negedge clk_12_5m);
            if (cfg_en) begin
                other_errs++;
                $display("cfg_en rose at %0t after a rejected packet", $time);
                break;
            end
        end
        check_reset_fields();
    endtask

    task automatic test_gap_restart();
        apply_reset();
        fill_stim();
        send_local(5);
        fill_stim();
        rec = stim;
        send_local(31);
        wait_cfg_en(100);
        check_record();
    endtask

    initial begin
        test_reset_state();
        test_local_record();
        test_lock();
        test_remote_record();
        test_rejected();
        test_gap_restart();
        $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
src/cmm_types_pkg.sv
src/cmm_parse_pkg.sv
src/cfg_pkt_parser.sv
src/cfg_write_ctrl.sv
src/cfg_field_regs.sv
src/self_cfg_mem.sv
testbench/tb_self_cfg_mem.sv
